//--- sim.f
+incdir+hw
hw/mips_pkg.sv
hw/control_unit.sv
hw/alu.sv
hw/register_file.sv
hw/fetch_unit.sv
hw/data_memory.sv
hw/mips_core.sv
verif/mips_core_sva.sv
verif/mips_core_tb.sv

//--- Makefile
# Verilator build and run for the MIPS core testbench
VERILATOR ?= verilator
TOP ?= mips_core_tb
FILELIST ?= sim.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert --timescale 1ns/1ns -Wno-fatal

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)

run: compile
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	@if grep -q "Regression failed" $(LOG) || ! grep -q "Regression passed" $(LOG); then \
		echo "Simulation reported failure, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- verif/mips_core_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "mips_defs.svh"

module mips_core_tb;
	import mips_pkg::*;

	localparam int RESET_CYCLES = 16;	// Also the load burst length

	logic clk = 1'b0;
	logic rst, run, prog_we, store_valid;
	pc_t prog_addr;
	word_t prog_data;
	store_t store, exp_st;
	store_t exp_q [$];					// Stores the model expects, in order
	word_t prog [`IMEM_DEPTH];
	int prog_len, st_addr, limit;
	int cycles = 0;
	int mism_cnt = 0;
	int miss_cnt = 0;
	int extra_cnt = 0;

	mips_core mips_core_i (.clk, .rst, .run, .prog_we, .prog_addr, .prog_data,
		.store_valid, .store);

	always #4 clk = ~clk;				// 8 ns period

	function automatic word_t r_op(input int funct, input int rs, input int rt, input int rd);
		return {6'h00, 5'(rs), 5'(rt), 5'(rd), 5'h00, 6'(funct)};
	endfunction

	function automatic word_t i_op(input int op, input int rs, input int rt, input int imm);
		return {6'(op), 5'(rs), 5'(rt), 16'(imm)};
	endfunction

	function automatic word_t j_op(input int op, input int target);
		return {6'(op), 26'(target)};
	endfunction

	function automatic void emit(input word_t w);
		prog[prog_len] = w;
		prog_len++;
	endfunction

	function automatic void store_reg(input int rt);
		emit(i_op(6'h2b, 0, rt, st_addr));	// SW rt to the next free slot
		st_addr += 4;
	endfunction

	function automatic void build_program();
		int functs [6] = '{6'h21, 6'h23, 6'h24, 6'h25, 6'h26, 6'h2a};
		int iops [4] = '{6'h09, 6'h0c, 6'h0d, 6'h0e};
		int p;
		prog_len = 0;
		st_addr = 0;
		store_reg(5);						// Registers start at zero
		store_reg(31);
		emit(i_op(6'h0f, 0, 1, $urandom));	// LUI then ORI gives a full random word
		emit(i_op(6'h0d, 1, 1, $urandom));
		emit(i_op(6'h0f, 0, 2, $urandom));
		emit(i_op(6'h09, 2, 2, $urandom));	// ADDIU sign extends
		store_reg(1);
		store_reg(2);
		foreach (functs[i])
		begin
			emit(r_op(functs[i], 1, 2, 3));
			store_reg(3);
			emit(r_op(functs[i], 2, 1, 3));	// Swapped operands, SLT both ways
			store_reg(3);
		end
		foreach (iops[i])
		begin
			for (int s = 1; s <= 2; s++)
			begin
				emit(i_op(iops[i], s, 3, $urandom));
				store_reg(3);
			end
		end
		emit(i_op(6'h3f, 1, 3, $urandom));	// Unknown opcodes leave $3 and memory alone
		emit(i_op(6'h2a, 0, 3, 0));
		store_reg(3);
		emit(i_op(6'h0f, 0, 4, $urandom));
		emit(i_op(6'h0d, 4, 4, $urandom));
		emit(i_op(6'h2b, 0, 4, 512));		// Word that the byte stores patch
		for (int l = 0; l < 4; l++)
		begin
			emit(i_op(6'h09, 0, 5, $urandom));
			emit(i_op(6'h28, 0, 5, 512 + l));	// SB into lane l
			emit(i_op(6'h23, 0, 6, 512));		// LW merged word
			store_reg(6);
			emit(i_op(6'h20, 0, 7, 512 + l));	// LB sign extends
			store_reg(7);
		end
		for (int k = 0; k < 4; k++)
		begin
			emit(i_op(6'h09, 0, 8, $urandom));
			if (k[0])
				emit(r_op(6'h21, 8, 0, 9));			// Equal operands
			else
				emit(i_op(6'h0e, 8, 9, $urandom | 1));	// Differs at least in bit 0
			emit(i_op(k < 2 ? 6'h04 : 6'h05, 8, 9, 2));	// Taken skips two words
			emit(i_op(6'h09, 0, 10, 16 + k));
			store_reg(10);
			emit(i_op(6'h09, 0, 10, 32 + k));		// Join point
			store_reg(10);
		end
		p = prog_len;
		emit(j_op(6'h03, p + 3));			// JAL, link p+1
		emit(i_op(6'h09, 0, 10, 99));
		store_reg(10);
		store_reg(31);
		p = prog_len;
		emit(j_op(6'h02, p + 2));
		store_reg(10);						// Skipped by J
		p = prog_len;
		emit(i_op(6'h09, 0, 11, p + 4));
		emit(r_op(6'h08, 11, 0, 0));		// JR
		store_reg(0);
		emit(i_op(6'h09, 0, 11, 7));
		store_reg(11);
		p = prog_len;
		emit(i_op(6'h09, 0, 12, p + 3));
		emit(r_op(6'h09, 12, 0, 13));		// JALR, link p+2 in $13
		store_reg(12);
		store_reg(13);
		emit(j_op(6'h02, prog_len));		// Parks on a self jump
	endfunction

	// ISA model on its own state, fills exp_q
	function automatic void run_model();
		word_t r [`NUM_REGS];
		word_t m [`DMEM_DEPTH];
		word_t ins, a, b, si, ea, val;
		pc_t pc, npc;
		logic [4:0] rd;
		logic we;
		logic [7:0] bt;
		for (int i = 0; i < `NUM_REGS; i++)
			r[i] = '0;
		for (int i = 0; i < `DMEM_DEPTH; i++)
			m[i] = '0;
		pc = pc_t'(`RESET_PC);
		while (prog[pc] != {6'h02, 26'(pc)})
		begin
			ins = prog[pc];
			a = r[ins[25:21]];
			b = r[ins[20:16]];
			si = {{16{ins[15]}}, ins[15:0]};
			ea = a + si;					// Also the ADDIU sum
			bt = m[ea[9:2]][8*ea[1:0] +: 8];
			npc = pc + 8'd1;
			rd = ins[20:16];
			we = 1'b1;
			val = ea;
			case (ins[31:26])
				6'h00:
				begin
					rd = ins[15:11];
					case (ins[5:0])
						6'h09: val = word_t'(npc);	// JALR link
						6'h21: val = a + b;
						6'h23: val = a - b;
						6'h24: val = a & b;
						6'h25: val = a | b;
						6'h26: val = a ^ b;
						6'h2a: val = {31'h0, $signed(a) < $signed(b)};
						default: we = 1'b0;
					endcase
				end
				6'h08, 6'h09: val = ea;
				6'h0c: val = a & {16'h0, ins[15:0]};
				6'h0d: val = a | {16'h0, ins[15:0]};
				6'h0e: val = a ^ {16'h0, ins[15:0]};
				6'h0f: val = {ins[15:0], 16'h0};
				6'h20: val = {{24{bt[7]}}, bt};
				6'h23: val = m[ea[9:2]];
				6'h03:
				begin
					rd = 5'(`RA_REG);
					val = word_t'(npc);
				end
				default: we = 1'b0;
			endcase
			if (we && rd != 5'd0)
				r[rd] = val;
			if (ins[31:26] == 6'h2b || ins[31:26] == 6'h28)
			begin
				exp_q.push_back({ea, ins[26] ? b : {24'h0, b[7:0]}, !ins[26]});
				if (ins[26])
					m[ea[9:2]] = b;
				else
					m[ea[9:2]][8*ea[1:0] +: 8] = b[7:0];
			end
			if (ins[31:27] == 5'b00010 && ((a == b) != ins[26]))
				npc = npc + pc_t'(si);		// BEQ, BNE taken
			else if (ins[31:27] == 5'b00001)
				npc = pc_t'(ins[25:0]);		// J, JAL
			else if (ins[31:26] == 6'h00 && ins[5:1] == 5'b00100)
				npc = pc_t'(a);				// JR, JALR
			pc = npc;
		end
	endfunction

	initial
	begin
		void'($urandom(32'hf3d2_1fd7));
		rst = 1'b1;
		run = 1'b0;
		prog_we = 1'b0;
		prog_addr = '0;
		prog_data = '0;
		build_program();
		run_model();
		limit = prog_len * 4 + ((prog_len + 15) / 16) * (RESET_CYCLES + 1);
		for (int base = 0; base < prog_len; base += RESET_CYCLES)
		begin
			for (int i = 0; i < RESET_CYCLES; i++)
			begin
				@(posedge clk);
				rst <= 1'b1;
				prog_we <= 1'b1;
				prog_addr <= pc_t'(base + i);
				prog_data <= (base + i < prog_len) ? prog[base + i] : '0;
			end
			@(posedge clk);
			rst <= 1'b0;					// Idle cycle between load bursts
			prog_we <= 1'b0;
		end
		@(posedge clk);
		run <= 1'b1;
		repeat (3)
		begin
			repeat ($urandom_range(12, 3)) @(posedge clk);
			run <= 1'b0;					// Pause
			repeat ($urandom_range(8, 1)) @(posedge clk);
			run <= 1'b1;
		end
		while (exp_q.size() != 0)
			@(posedge clk);
		repeat (8) @(posedge clk);			// Window for stray stores
		$display("Errors: %0d mismatched, %0d missing, %0d extra", mism_cnt, miss_cnt, extra_cnt);
		if (mism_cnt + miss_cnt + extra_cnt == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

	always @(negedge clk)
	begin
		if (store_valid)
		begin
			assert (exp_q.size() != 0)
			else
			begin
				extra_cnt++;
				$display("Store at %0t to address %h came after the last expected store",
					$time, store.addr);
			end
			if (exp_q.size() != 0)
			begin
				exp_st = exp_q.pop_front();
				assert (store == exp_st)
				else
				begin
					mism_cnt++;
					$display("FAIL %0t: store got addr %h data %h byte %b, expected %h %h %b",
						$time, store.addr, store.data, store.byte_mode,
						exp_st.addr, exp_st.data, exp_st.byte_mode);
				end
			end
		end
	end

	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycles >= limit)
		begin
			miss_cnt = exp_q.size();
			$display("Timeout after %0d cycles, %0d expected stores never appeared",
				cycles, miss_cnt);
			$display("Errors: %0d mismatched, %0d missing, %0d extra", mism_cnt, miss_cnt, extra_cnt);
			$display("Regression failed");
			$finish;
		end
	end

endmodule

`default_nettype wire

//--- verif/mips_core_sva.sv
`timescale 1ns/1ns
`default_nettype none

module mips_core_sva (
	input logic clk,
	input logic rst,
	input logic run,
	input logic store_valid,
	input mips_pkg::word_t instr,
	input mips_pkg::word_t rs_data,
	input mips_pkg::ctrl_t ctrl
);
	import mips_pkg::*;

	// No store strobe in reset or while paused
	a_no_store_idle: assert property (@(posedge clk) (rst || !run) |-> !store_valid)
		else $error("store_valid high during reset or with run low");

	// $0 reads as zero
	a_zero_reg: assert property (@(posedge clk) disable iff (rst)
		(instr[25:21] == 5'd0) |-> (rs_data == '0))
		else $error("register 0 read a nonzero value");

	a_unknown_nop: assert property (@(posedge clk) disable iff (rst)
		!(instr[31:26] inside {6'h00, 6'h02, 6'h03, 6'h04, 6'h05, 6'h08, 6'h09, 6'h0c,
			6'h0d, 6'h0e, 6'h0f, 6'h20, 6'h23, 6'h28, 6'h2b})
		|-> (!ctrl.reg_we && !ctrl.mem_we))
		else $error("unknown opcode enabled a write");

endmodule

bind mips_core mips_core_sva sva_i (.clk, .rst, .run, .store_valid, .instr, .rs_data, .ctrl);

`default_nettype wire

//--- hw/mips_core.sv
`timescale 1ns/1ns
`default_nettype none

`include "mips_defs.svh"

module mips_core (
	input logic clk,
	input logic rst,
	input logic run,					// One instruction per clock while high
	input logic prog_we,
	input mips_pkg::pc_t prog_addr,
	input mips_pkg::word_t prog_data,
	output logic store_valid,
	output mips_pkg::store_t store
);
	import mips_pkg::*;

	word_t instr, rs_data, rt_data, imm_ext, alu_b, alu_result, mem_data, wr_data;
	pc_t pc_plus1;
	ctrl_t ctrl;
	reg_addr_t wr_addr;
	logic zero;
	logic taken;

	fetch_unit fetch_i (.clk, .rst, .run, .prog_we, .prog_addr, .prog_data,
		.pc_src(ctrl.pc_src), .taken, .imm(imm_ext), .jump_index(pc_t'(instr[25:0])),
		.rs_data, .instr, .pc_plus1);

	control_unit ctrl_i (.opcode(instr[31:26]), .funct(instr[5:0]), .ctrl);

	register_file regs_i (.clk, .rst, .rs_addr(instr[25:21]), .rt_addr(instr[20:16]),
		.wr_addr, .we(ctrl.reg_we && run), .wr_data, .rs_data, .rt_data);

	alu alu_i (.op(ctrl.alu_op), .funct(instr[5:0]), .a(rs_data), .b(alu_b),
		.result(alu_result), .zero);

	data_memory dmem_i (.clk, .rst, .run, .addr(alu_result), .wr_data(rt_data),
		.we(ctrl.mem_we), .byte_mode(ctrl.byte_mode), .rd_data(mem_data), .store_valid, .store);

	assign imm_ext = ctrl.imm_signed ? {{16{instr[15]}}, instr[15:0]} : {16'h0, instr[15:0]};
	assign alu_b = ctrl.alu_imm ? imm_ext : rt_data;
	assign taken = (zero == ctrl.branch_eq);	// BEQ on zero, BNE on nonzero

	always_comb
	begin
		case (ctrl.reg_dst)
			DST_RD: wr_addr = instr[15:11];
			DST_RA: wr_addr = reg_addr_t'(`RA_REG);
			default: wr_addr = instr[20:16];	// rt
		endcase
		case (ctrl.wb_src)
			WB_MEM: wr_data = mem_data;
			WB_LINK: wr_data = word_t'(pc_plus1);	// Return address PC+1
			default: wr_data = alu_result;
		endcase
	end

endmodule

`default_nettype wire

//--- hw/data_memory.sv
`timescale 1ns/1ns
`default_nettype none

`include "mips_defs.svh"

module data_memory (
	input logic clk,
	input logic rst,
	input logic run,
	input mips_pkg::word_t addr,		// Byte address
	input mips_pkg::word_t wr_data,
	input logic we,
	input logic byte_mode,
	output mips_pkg::word_t rd_data,
	output logic store_valid,
	output mips_pkg::store_t store
);
	import mips_pkg::*;

	localparam int AW = $clog2(`DMEM_DEPTH);

	word_t mem [`DMEM_DEPTH];
	logic [AW-1:0] word_idx;
	logic [1:0] lane;				// Byte lane, little-endian
	word_t rd_word;
	logic [7:0] rd_byte;

	assign word_idx = addr[AW+1:2];
	assign lane = addr[1:0];
	assign rd_word = mem[word_idx];
	assign rd_byte = rd_word[8*lane +: 8];
	assign rd_data = byte_mode ? {{24{rd_byte[7]}}, rd_byte} : rd_word;	// LB sign extends

	// Write strobe, one per retired SW/SB
	assign store_valid = we && run && !rst;
	assign store.addr = addr;
	assign store.data = byte_mode ? {24'h0, wr_data[7:0]} : wr_data;	// SB shows its byte only
	assign store.byte_mode = byte_mode;

	always_ff @(posedge clk)
	begin
		if (store_valid)
		begin
			if (byte_mode)
				mem[word_idx][8*lane +: 8] <= wr_data[7:0];	// Other lanes kept
			else
				mem[word_idx] <= wr_data;
		end
	end

endmodule

`default_nettype wire

//--- hw/fetch_unit.sv
`timescale 1ns/1ns
`default_nettype none

`include "mips_defs.svh"

module fetch_unit (
	input logic clk,
	input logic rst,
	input logic run,
	input logic prog_we,
	input mips_pkg::pc_t prog_addr,
	input mips_pkg::word_t prog_data,
	input mips_pkg::pc_src_t pc_src,
	input logic taken,				// Branch condition from the core
	input mips_pkg::word_t imm,		// Extended branch offset
	input mips_pkg::pc_t jump_index,
	input mips_pkg::word_t rs_data,
	output mips_pkg::word_t instr,
	output mips_pkg::pc_t pc_plus1
);
	import mips_pkg::*;

	word_t imem [`IMEM_DEPTH];
	pc_t pc;
	pc_t next_pc;

	// Program load only while held in reset
	always_ff @(posedge clk)
	begin
		if (rst && prog_we)
			imem[prog_addr] <= prog_data;
	end

	always_ff @(posedge clk)
	begin
		if (rst)
			pc <= pc_t'(`RESET_PC);
		else if (run)				// PC holds while paused
			pc <= next_pc;
	end

	assign pc_plus1 = pc + 1'b1;	// Word addressed
	assign instr = imem[pc];

	always_comb
	begin
		case (pc_src)
			PC_BRANCH: next_pc = taken ? pc_plus1 + pc_t'(imm) : pc_plus1;
			PC_JUMP: next_pc = jump_index;
			PC_REG: next_pc = pc_t'(rs_data);	// JR/JALR
			default: next_pc = pc_plus1;
		endcase
	end

endmodule

`default_nettype wire

//--- hw/register_file.sv
`timescale 1ns/1ns
`default_nettype none

`include "mips_defs.svh"

module register_file (
	input logic clk,
	input logic rst,
	input mips_pkg::reg_addr_t rs_addr,
	input mips_pkg::reg_addr_t rt_addr,
	input mips_pkg::reg_addr_t wr_addr,
	input logic we,					// Decoded reg_we qualified by run
	input mips_pkg::word_t wr_data,
	output mips_pkg::word_t rs_data,
	output mips_pkg::word_t rt_data
);
	import mips_pkg::*;

	word_t regs [`NUM_REGS];

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			for (int i = 0; i < `NUM_REGS; i++)
				regs[i] <= '0;			// All registers start at zero
		end
		else if (we && (wr_addr != '0))	// $0 is never written
			regs[wr_addr] <= wr_data;
	end

	// Combinational reads
	assign rs_data = regs[rs_addr];
	assign rt_data = regs[rt_addr];

endmodule

`default_nettype wire

//--- hw/alu.sv
`timescale 1ns/1ns
`default_nettype none

module alu (
	input mips_pkg::alu_op_t op,
	input mips_pkg::funct_t funct,
	input mips_pkg::word_t a,
	input mips_pkg::word_t b,
	output mips_pkg::word_t result,
	output logic zero
);
	import mips_pkg::*;

	alu_op_t eff_op;		// Operation after funct decode

	always_comb
	begin
		eff_op = op;
		if (op == FUNCT)
		begin
			case (funct)
				6'b100011: eff_op = SUB;	// SUBU
				6'b100100: eff_op = AND;
				6'b100101: eff_op = OR;
				6'b100110: eff_op = XOR;
				6'b101010: eff_op = SLT;
				default: eff_op = ADD;		// ADDU
			endcase
		end
	end

	always_comb
	begin
		case (eff_op)
			SUB: result = a - b;
			AND: result = a & b;
			OR: result = a | b;
			XOR: result = a ^ b;
			SLT: result = word_t'($signed(a) < $signed(b));	// Signed compare
			LUI: result = {b[15:0], 16'h0000};		// Low half of b moves up
			default: result = a + b;
		endcase
	end

	assign zero = (result == '0);	// Used by BEQ/BNE

endmodule

`default_nettype wire

//--- hw/control_unit.sv
`timescale 1ns/1ns
`default_nettype none

module control_unit (
	input mips_pkg::opcode_t opcode,
	input mips_pkg::funct_t funct,
	output mips_pkg::ctrl_t ctrl
);
	import mips_pkg::*;

	always_comb
	begin
		// NOP values, every arm overrides only what it needs
		ctrl.pc_src = PC_NEXT;		// PC = PC+1
		ctrl.reg_dst = DST_RT;
		ctrl.wb_src = WB_ALU;
		ctrl.alu_op = ADD;
		ctrl.alu_imm = 1'b0;		// Second operand is rt
		ctrl.reg_we = 1'b0;			// No register write
		ctrl.mem_we = 1'b0;			// No memory write
		ctrl.branch_eq = 1'b1;
		ctrl.imm_signed = 1'b1;
		ctrl.byte_mode = 1'b0;		// Word access
		case (opcode)
			6'b000000:				// R-type
			begin
				case (funct)
					6'b001000:		// JR
						ctrl.pc_src = PC_REG;		// PC = rs
					6'b001001:		// JALR
					begin
						ctrl.pc_src = PC_REG;		// PC = rs
						ctrl.reg_dst = DST_RD;		// Link goes to rd, 31 in the usual form
						ctrl.wb_src = WB_LINK;		// Writes PC+1
						ctrl.reg_we = 1'b1;
					end
					6'b100001, 6'b100011, 6'b100100, 6'b100101, 6'b100110, 6'b101010:
					begin	// ADDU SUBU AND OR XOR SLT
						ctrl.reg_dst = DST_RD;		// Three register form
						ctrl.alu_op = FUNCT;		// ALU looks at funct
						ctrl.reg_we = 1'b1;
					end
					default: ;		// Unsupported funct stays a NOP
				endcase
			end
			6'b001000, 6'b001001:	// ADDI, ADDIU, no overflow trap
			begin
				ctrl.alu_imm = 1'b1;
				ctrl.reg_we = 1'b1;		// Signed immediate from the NOP values
			end
			6'b001100, 6'b001101, 6'b001110:	// ANDI ORI XORI
			begin
				ctrl.alu_op = (opcode[1:0] == 2'b00) ? AND :
					(opcode[1:0] == 2'b01) ? OR : XOR;
				ctrl.alu_imm = 1'b1;
				ctrl.reg_we = 1'b1;
				ctrl.imm_signed = 1'b0;		// Logic ops zero extend
			end
			6'b001111:				// LUI
			begin
				ctrl.alu_op = LUI;			// imm << 16
				ctrl.alu_imm = 1'b1;
				ctrl.reg_we = 1'b1;
				ctrl.imm_signed = 1'b0;
			end
			6'b100011, 6'b100000:	// LW, LB
			begin
				ctrl.wb_src = WB_MEM;		// Load data to rt
				ctrl.alu_imm = 1'b1;		// Address = rs + offset
				ctrl.reg_we = 1'b1;
				ctrl.byte_mode = ~opcode[0];	// LB has bit 0 clear
			end
			6'b101011, 6'b101000:	// SW, SB
			begin
				ctrl.alu_imm = 1'b1;		// Address = rs + offset
				ctrl.mem_we = 1'b1;
				ctrl.byte_mode = ~opcode[0];
			end
			6'b000100, 6'b000101:	// BEQ, BNE
			begin
				ctrl.pc_src = PC_BRANCH;
				ctrl.alu_op = SUB;			// Zero flag gives rs == rt
				ctrl.branch_eq = ~opcode[0];	// BNE has bit 0 set
			end
			6'b000010:				// J
				ctrl.pc_src = PC_JUMP;
			6'b000011:				// JAL
			begin
				ctrl.pc_src = PC_JUMP;
				ctrl.reg_dst = DST_RA;		// Link in $ra
				ctrl.wb_src = WB_LINK;
				ctrl.reg_we = 1'b1;
			end
			default: ;				// Unknown opcode acts as a NOP
		endcase
	end

endmodule

`default_nettype wire

//--- hw/mips_pkg.sv
`default_nettype none

`include "mips_defs.svh"

package mips_pkg;

	typedef logic [31:0] word_t;						// Data word
	typedef logic [$clog2(`IMEM_DEPTH)-1:0] pc_t;		// Word address into instruction memory
	typedef logic [$clog2(`NUM_REGS)-1:0] reg_addr_t;	// Register index
	typedef logic [5:0] opcode_t;						// instr[31:26]
	typedef logic [5:0] funct_t;						// instr[5:0]

	// ALU operations, FUNCT hands the choice to the funct field
	typedef enum logic [2:0] {
		ADD, SUB, AND, OR, XOR, SLT, LUI, FUNCT
	} alu_op_t;

	// Next PC sources
	typedef enum logic [1:0] {
		PC_BRANCH,		// PC+1+imm when taken
		PC_JUMP,		// Jump index
		PC_REG,			// rs
		PC_NEXT			// PC+1
	} pc_src_t;

	typedef enum logic [1:0] {
		DST_RT, DST_RD, DST_RA
	} reg_dst_t;

	typedef enum logic [1:0] {
		WB_ALU, WB_MEM, WB_LINK
	} wb_src_t;

	typedef struct packed {
		pc_src_t pc_src;
		reg_dst_t reg_dst;
		wb_src_t wb_src;
		alu_op_t alu_op;
		logic alu_imm;		// Second ALU operand is the immediate
		logic reg_we;
		logic mem_we;
		logic branch_eq;	// 1 for BEQ, 0 for BNE
		logic imm_signed;	// Sign extend the immediate
		logic byte_mode;	// LB/SB
	} ctrl_t;

	// One store as seen outside the core
	typedef struct packed {
		word_t addr;		// Byte address
		word_t data;
		logic byte_mode;
	} store_t;

endpackage

`default_nettype wire

//--- hw/mips_defs.svh
`ifndef MIPS_DEFS_SVH
`define MIPS_DEFS_SVH

// Memory sizes, all in 32-bit words
`define IMEM_DEPTH 256		// Instruction memory words
`define DMEM_DEPTH 256		// Data memory words

// Register file
`define NUM_REGS 32			// General purpose registers, $0 reads as zero
`define RA_REG 31			// Link register for JAL

// Fetch
`define RESET_PC 0			// First word executed after reset

`endif
